/* Makefile */
TOP = tb_vchess

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -f flist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* attack/attack_collector.sv */
`timescale 1ns/1ps

module attack_collector import vchess_pkg::*; (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     loaded,
   input  logic                     clear,
   input  logic                     start,
   input  logic [BOARD_WIDTH - 1:0] board,
   input  logic [63:0]              white_hits,
   input  logic [63:0]              black_hits,
   output logic [63:0]              white_attack,
   output logic [63:0]              black_attack,
   output logic                     white_in_check,
   output logic                     black_in_check,
   output logic                     ready
);

   logic [63:0] white_king;
   logic [63:0] black_king;

   // King locations, more than one of each is tolerated
   always_comb
   begin
      for (int s = 0; s < 64; s++)
      begin
         white_king[s] = (board[s * PIECE_WIDTH +: PIECE_WIDTH] == KING);
         black_king[s] = (board[s * PIECE_WIDTH +: PIECE_WIDTH] == BLACK_KING);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         white_attack <= '0;
         black_attack <= '0;
         white_in_check <= 1'b0;
         black_in_check <= 1'b0;
         ready <= 1'b0;
      end
      else
      begin
         if (loaded)
         begin
            white_attack <= white_hits;
            black_attack <= black_hits;
            white_in_check <= |(white_king & black_hits);
            black_in_check <= |(black_king & white_hits);
         end
         if (clear || start)
            ready <= 1'b0;                         // Results stale
         else if (loaded)
            ready <= 1'b1;
      end
   end

endmodule

/* attack/board_latch.sv */
`timescale 1ns/1ps

module board_latch import vchess_pkg::*; (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  logic [BOARD_WIDTH - 1:0] new_board,
   input  logic [8:0]               new_side,
   output logic [BOARD_WIDTH - 1:0] board,
   output logic [8:0]               side,
   output logic                     loaded,
   output logic                     busy
);

   // Copy held apart from the rank registers, so the host may edit them mid-analysis
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         board <= '0;
         side <= '0;
         loaded <= 1'b0;
      end
      else
      begin
         loaded <= start;                          // Board valid from here on
         if (start)
         begin
            board <= new_board;
            side <= new_side;
         end
      end
   end

   // Covers the start cycle and the cycle the square units settle
   assign busy = start | loaded;

endmodule

/* attack/square_attack.sv */
`timescale 1ns/1ps

module square_attack import vchess_pkg::*; #(
   parameter int SQUARE = 0
) (
   input  logic [BOARD_WIDTH - 1:0] board,
   output logic                     white_hit,
   output logic                     black_hit
);

   localparam int TARGET_FILE = SQUARE % 8;
   localparam int TARGET_RANK = SQUARE / 8;

   // Off-board squares read as empty, which gives the edge guards
   function automatic piece_t piece_at(input logic [BOARD_WIDTH - 1:0] b,
                                       input int file, input int rank);
      if (file < 0 || file > 7 || rank < 0 || rank > 7)
         return EMPTY;
      return piece_t'(b[(rank * 8 + file) * PIECE_WIDTH +: PIECE_WIDTH]);
   endfunction

   always_comb
   begin
      piece_t p;
      int     dist2;

      white_hit = 1'b0;
      black_hit = 1'b0;
      // Scan the 5x5 window around the target; dr and df are source minus target
      for (int dr = -2; dr <= 2; dr++)
      begin
         for (int df = -2; df <= 2; df++)
         begin
            p = piece_at(board, TARGET_FILE + df, TARGET_RANK + dr);
            dist2 = df * df + dr * dr;
            case (p)
               PAWN:         if (dr == -1 && dist2 == 2) white_hit = 1'b1; // From below
               KNIGHT:       if (dist2 == 5) white_hit = 1'b1;
               KING:         if (dist2 == 1 || dist2 == 2) white_hit = 1'b1;
               BLACK_PAWN:   if (dr == 1 && dist2 == 2) black_hit = 1'b1;  // From above
               BLACK_KNIGHT: if (dist2 == 5) black_hit = 1'b1;
               BLACK_KING:   if (dist2 == 1 || dist2 == 2) black_hit = 1'b1;
               BISHOP, ROOK, QUEEN,
               BLACK_BISHOP, BLACK_ROOK, BLACK_QUEEN: ;                    // No rays yet
               default: ;
            endcase
         end
      end
   end

endmodule

/* common/vchess_pkg.sv */
package vchess_pkg;

   localparam int PIECE_WIDTH = 4;                 // Bits per square
   localparam int SIDE_WIDTH = 8 * PIECE_WIDTH;    // Bits per rank
   localparam int BOARD_WIDTH = 8 * SIDE_WIDTH;    // Bits per board

   // Bit 3 marks a black piece
   typedef enum logic [PIECE_WIDTH - 1:0] {
      EMPTY        = 4'd0,
      PAWN         = 4'd1,
      KNIGHT       = 4'd2,
      BISHOP       = 4'd3,
      ROOK         = 4'd4,
      QUEEN        = 4'd5,
      KING         = 4'd6,
      BLACK_PAWN   = 4'd9,
      BLACK_KNIGHT = 4'd10,
      BLACK_BISHOP = 4'd11,
      BLACK_ROOK   = 4'd12,
      BLACK_QUEEN  = 4'd13,
      BLACK_KING   = 4'd14
   } piece_t;

   // Word addresses, byte address divided by 4
   typedef enum logic [7:0] {
      REG_STATUS  = 8'd0,
      REG_SIDE    = 8'd2,
      REG_RANK0   = 8'd8,
      REG_RANK1   = 8'd9,
      REG_RANK2   = 8'd10,
      REG_RANK3   = 8'd11,
      REG_RANK4   = 8'd12,
      REG_RANK5   = 8'd13,
      REG_RANK6   = 8'd14,
      REG_RANK7   = 8'd15,
      REG_WATK_LO = 8'd128,
      REG_WATK_HI = 8'd129,
      REG_BATK_LO = 8'd130,
      REG_BATK_HI = 8'd131,
      REG_CHECK   = 8'd132,
      REG_LSIDE   = 8'd133,
      REG_LRANK0  = 8'd172,
      REG_LRANK1  = 8'd173,
      REG_LRANK2  = 8'd174,
      REG_LRANK3  = 8'd175,
      REG_LRANK4  = 8'd176,
      REG_LRANK5  = 8'd177,
      REG_LRANK6  = 8'd178,
      REG_LRANK7  = 8'd179
   } reg_addr_t;

endpackage

/* flist.f */
common/vchess_pkg.sv
hw/axi4lite_write.sv
hw/control.sv
attack/board_latch.sv
attack/square_attack.sv
attack/attack_collector.sv
hw/vchess_top.sv
tests/tb_vchess.sv

/* hw/axi4lite_write.sv */
`timescale 1ns/1ps

module axi4lite_write #(
   parameter int AXI_ADDR_WIDTH = 40
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [AXI_ADDR_WIDTH - 1:0] axi_awaddr,
   input  logic [2:0]                  axi_awprot,
   input  logic                        axi_awvalid,
   input  logic [31:0]                 axi_wdata,
   input  logic [3:0]                  axi_wstrb,
   input  logic                        axi_wvalid,
   input  logic                        axi_bready,
   output logic                        axi_awready,
   output logic                        axi_wready,
   output logic                        axi_bvalid,
   output logic [1:0]                  axi_bresp,
   output logic [AXI_ADDR_WIDTH - 1:0] wr_addr,
   output logic [31:0]                 wr_data,
   output logic                        wr_valid
);

   typedef enum logic {
      IDLE,
      RESP
   } state_t;

   state_t state;
   logic   accept;

   // Both channels must be present, and no response may be outstanding
   assign accept = (state == IDLE) && axi_awvalid && axi_wvalid;

   assign axi_awready = accept;
   assign axi_wready = accept;
   assign axi_bvalid = (state == RESP);
   assign axi_bresp = 2'b00;                       // Always OKAY

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         wr_valid <= 1'b0;
      end
      else
      begin
         wr_valid <= accept;                       // One pulse per write
         case (state)
            IDLE: if (accept) state <= RESP;
            RESP: if (axi_bready) state <= IDLE;   // Hold bvalid until taken
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         wr_addr <= axi_awaddr;
         wr_data <= axi_wdata;
      end
   end

endmodule

/* hw/control.sv */
`timescale 1ns/1ps

module control import vchess_pkg::*; #(
   parameter int AXI_ADDR_WIDTH = 40
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [AXI_ADDR_WIDTH - 1:0] axi_araddr,
   input  logic [2:0]                  axi_arprot,
   input  logic                        axi_arvalid,
   input  logic [AXI_ADDR_WIDTH - 1:0] axi_awaddr,
   input  logic [2:0]                  axi_awprot,
   input  logic                        axi_awvalid,
   input  logic                        axi_bready,
   input  logic                        axi_rready,
   input  logic [31:0]                 axi_wdata,
   input  logic [3:0]                  axi_wstrb,
   input  logic                        axi_wvalid,
   output logic                        axi_arready,
   output logic                        axi_awready,
   output logic [1:0]                  axi_bresp,
   output logic                        axi_bvalid,
   output logic [31:0]                 axi_rdata,
   output logic [1:0]                  axi_rresp,
   output logic                        axi_rvalid,
   output logic                        axi_wready,
   input  logic                        ready,
   input  logic                        busy,
   input  logic [63:0]                 white_attack,
   input  logic [63:0]                 black_attack,
   input  logic                        white_in_check,
   input  logic                        black_in_check,
   input  logic [BOARD_WIDTH - 1:0]    latched_board,
   input  logic [8:0]                  latched_side,
   output logic                        start,
   output logic                        clear,
   output logic [BOARD_WIDTH - 1:0]    new_board,
   output logic [8:0]                  new_side
);

   logic [AXI_ADDR_WIDTH - 1:0] wr_addr;
   logic [31:0]                 wr_data;
   logic                        wr_valid;
   logic                        wr_mapped;
   logic                        rd_mapped;
   reg_addr_t                   wr_reg;
   reg_addr_t                   rd_reg;
   logic [7:0]                  lrank_index;
   logic [31:0]                 rd_value;

   axi4lite_write #(
      .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)
   ) u_write (
      .clk(clk),
      .reset(reset),
      .axi_awaddr(axi_awaddr),
      .axi_awprot(axi_awprot),
      .axi_awvalid(axi_awvalid),
      .axi_wdata(axi_wdata),
      .axi_wstrb(axi_wstrb),
      .axi_wvalid(axi_wvalid),
      .axi_bready(axi_bready),
      .axi_awready(axi_awready),
      .axi_wready(axi_wready),
      .axi_bvalid(axi_bvalid),
      .axi_bresp(axi_bresp),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .wr_valid(wr_valid)
   );

   assign axi_arready = 1'b1;                      // Always ready
   assign axi_rresp = 2'b00;

   // Register space is 1 KB, anything above it is unmapped
   assign wr_mapped = (wr_addr[AXI_ADDR_WIDTH - 1:10] == '0);
   assign rd_mapped = (axi_araddr[AXI_ADDR_WIDTH - 1:10] == '0);
   assign wr_reg = reg_addr_t'(wr_addr[9:2]);
   assign rd_reg = reg_addr_t'(axi_araddr[9:2]);
   assign lrank_index = rd_reg - REG_LRANK0;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start <= 1'b0;
         clear <= 1'b0;
         new_board <= '0;
         new_side <= '0;
      end
      else
      begin
         start <= 1'b0;
         clear <= 1'b0;
         if (wr_valid && wr_mapped)
         begin
            case (wr_reg)
               REG_STATUS:
               begin
                  start <= wr_data[0];
                  clear <= wr_data[1];
               end
               REG_SIDE: new_side <= wr_data[8:0];
               REG_RANK0, REG_RANK1, REG_RANK2, REG_RANK3,
               REG_RANK4, REG_RANK5, REG_RANK6, REG_RANK7:
                  new_board[wr_reg[2:0] * SIDE_WIDTH +: SIDE_WIDTH] <= wr_data;
               default: ;
            endcase
         end
      end
   end

   always_comb
   begin
      rd_value = '0;
      case (rd_reg)
         REG_STATUS:  rd_value = {30'd0, busy, ready};
         REG_SIDE:    rd_value = {23'd0, new_side};
         REG_RANK0, REG_RANK1, REG_RANK2, REG_RANK3,
         REG_RANK4, REG_RANK5, REG_RANK6, REG_RANK7:
            rd_value = new_board[rd_reg[2:0] * SIDE_WIDTH +: SIDE_WIDTH];
         REG_WATK_LO: rd_value = white_attack[31:0];
         REG_WATK_HI: rd_value = white_attack[63:32];
         REG_BATK_LO: rd_value = black_attack[31:0];
         REG_BATK_HI: rd_value = black_attack[63:32];
         REG_CHECK:   rd_value = {30'd0, black_in_check, white_in_check};
         REG_LSIDE:   rd_value = {23'd0, latched_side};
         REG_LRANK0, REG_LRANK1, REG_LRANK2, REG_LRANK3,
         REG_LRANK4, REG_LRANK5, REG_LRANK6, REG_LRANK7:
            rd_value = latched_board[lrank_index[2:0] * SIDE_WIDTH +: SIDE_WIDTH];
         default:     rd_value = '0;
      endcase
      if (!rd_mapped)
         rd_value = '0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         axi_rvalid <= 1'b0;
      else if (axi_arvalid)
         axi_rvalid <= 1'b1;
      else if (axi_rready)
         axi_rvalid <= 1'b0;
   end

   // A new request while rvalid is high just reloads the data
   always_ff @(posedge clk)
   begin
      if (axi_arvalid)
         axi_rdata <= rd_value;
   end

endmodule

/* hw/vchess_top.sv */
`timescale 1ns/1ps

module vchess_top import vchess_pkg::*; #(
   parameter int AXI_ADDR_WIDTH = 40
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [AXI_ADDR_WIDTH - 1:0] axi_araddr,
   input  logic [2:0]                  axi_arprot,
   input  logic                        axi_arvalid,
   input  logic [AXI_ADDR_WIDTH - 1:0] axi_awaddr,
   input  logic [2:0]                  axi_awprot,
   input  logic                        axi_awvalid,
   input  logic                        axi_bready,
   input  logic                        axi_rready,
   input  logic [31:0]                 axi_wdata,
   input  logic [3:0]                  axi_wstrb,
   input  logic                        axi_wvalid,
   output logic                        axi_arready,
   output logic                        axi_awready,
   output logic [1:0]                  axi_bresp,
   output logic                        axi_bvalid,
   output logic [31:0]                 axi_rdata,
   output logic [1:0]                  axi_rresp,
   output logic                        axi_rvalid,
   output logic                        axi_wready
);

   logic                     start;
   logic                     clear;
   logic                     loaded;
   logic                     busy;
   logic                     ready;
   logic [BOARD_WIDTH - 1:0] new_board;
   logic [8:0]               new_side;
   logic [BOARD_WIDTH - 1:0] board;
   logic [8:0]               side;
   logic [63:0]              white_hits;
   logic [63:0]              black_hits;
   logic [63:0]              white_attack;
   logic [63:0]              black_attack;
   logic                     white_in_check;
   logic                     black_in_check;

   control #(
      .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)
   ) u_control (
      .clk(clk),
      .reset(reset),
      .axi_araddr(axi_araddr),
      .axi_arprot(axi_arprot),
      .axi_arvalid(axi_arvalid),
      .axi_awaddr(axi_awaddr),
      .axi_awprot(axi_awprot),
      .axi_awvalid(axi_awvalid),
      .axi_bready(axi_bready),
      .axi_rready(axi_rready),
      .axi_wdata(axi_wdata),
      .axi_wstrb(axi_wstrb),
      .axi_wvalid(axi_wvalid),
      .axi_arready(axi_arready),
      .axi_awready(axi_awready),
      .axi_bresp(axi_bresp),
      .axi_bvalid(axi_bvalid),
      .axi_rdata(axi_rdata),
      .axi_rresp(axi_rresp),
      .axi_rvalid(axi_rvalid),
      .axi_wready(axi_wready),
      .ready(ready),
      .busy(busy),
      .white_attack(white_attack),
      .black_attack(black_attack),
      .white_in_check(white_in_check),
      .black_in_check(black_in_check),
      .latched_board(board),
      .latched_side(side),
      .start(start),
      .clear(clear),
      .new_board(new_board),
      .new_side(new_side)
   );

   board_latch u_latch (
      .clk(clk),
      .reset(reset),
      .start(start),
      .new_board(new_board),
      .new_side(new_side),
      .board(board),
      .side(side),
      .loaded(loaded),
      .busy(busy)
   );

   // One attack test per target square
   for (genvar s = 0; s < 64; s++)
   begin : g_square
      square_attack #(
         .SQUARE(s)
      ) u_square (
         .board(board),
         .white_hit(white_hits[s]),
         .black_hit(black_hits[s])
      );
   end

   attack_collector u_collector (
      .clk(clk),
      .reset(reset),
      .loaded(loaded),
      .clear(clear),
      .start(start),
      .board(board),
      .white_hits(white_hits),
      .black_hits(black_hits),
      .white_attack(white_attack),
      .black_attack(black_attack),
      .white_in_check(white_in_check),
      .black_in_check(black_in_check),
      .ready(ready)
   );

endmodule

/* tests/tb_vchess.sv */
`timescale 1ns/1ps

module tb_vchess import vchess_pkg::*;;

   localparam int ADDR_WIDTH = 40;
   localparam int RANDOM_BOARDS = 20;
   localparam int TEST_COUNT = 6 + RANDOM_BOARDS;  // Each random board counts as a test

   logic                    clk;
   logic                    reset;
   logic [ADDR_WIDTH - 1:0] axi_araddr;
   logic [2:0]              axi_arprot;
   logic                    axi_arvalid;
   logic [ADDR_WIDTH - 1:0] axi_awaddr;
   logic [2:0]              axi_awprot;
   logic                    axi_awvalid;
   logic                    axi_bready;
   logic                    axi_rready;
   logic [31:0]             axi_wdata;
   logic [3:0]              axi_wstrb;
   logic                    axi_wvalid;
   logic                    axi_arready;
   logic                    axi_awready;
   logic [1:0]              axi_bresp;
   logic                    axi_bvalid;
   logic [31:0]             axi_rdata;
   logic [1:0]              axi_rresp;
   logic                    axi_rvalid;
   logic                    axi_wready;

   int          checks;
   int          errors;
   logic [31:0] rand_state;

   vchess_top #(
      .AXI_ADDR_WIDTH(ADDR_WIDTH)
   ) DUT (
      .clk(clk),
      .reset(reset),
      .axi_araddr(axi_araddr),
      .axi_arprot(axi_arprot),
      .axi_arvalid(axi_arvalid),
      .axi_awaddr(axi_awaddr),
      .axi_awprot(axi_awprot),
      .axi_awvalid(axi_awvalid),
      .axi_bready(axi_bready),
      .axi_rready(axi_rready),
      .axi_wdata(axi_wdata),
      .axi_wstrb(axi_wstrb),
      .axi_wvalid(axi_wvalid),
      .axi_arready(axi_arready),
      .axi_awready(axi_awready),
      .axi_bresp(axi_bresp),
      .axi_bvalid(axi_bvalid),
      .axi_rdata(axi_rdata),
      .axi_rresp(axi_rresp),
      .axi_rvalid(axi_rvalid),
      .axi_wready(axi_wready)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;                           // 20 ns period
   end

   initial
   begin
      #(TEST_COUNT * 2000);
      $display("Watchdog expired before the tests finished");
      $display("Testbench failed");
      $finish;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   // Attack rules seen from each source piece; sliders attack nothing
   function automatic void attack_model(input logic [BOARD_WIDTH - 1:0] b,
                                        output logic [63:0] w_map, output logic [63:0] b_map,
                                        output logic w_check, output logic b_check);
      logic [3:0] p;
      int         tf;
      int         tr;
      int         t;
      logic       knight_step;
      logic       king_step;

      w_map = '0;
      b_map = '0;
      for (int s = 0; s < 64; s++)
      begin
         p = b[s * 4 +: 4];
         for (int dr = -2; dr <= 2; dr++)
         begin
            for (int df = -2; df <= 2; df++)
            begin
               tf = s % 8 + df;
               tr = s / 8 + dr;
               if (tf >= 0 && tf < 8 && tr >= 0 && tr < 8)
               begin
                  t = tr * 8 + tf;
                  knight_step = (df * dr == 2) || (df * dr == -2);
                  king_step = (df != 0 || dr != 0) && df * df <= 1 && dr * dr <= 1;
                  case (p)
                     PAWN:         if (dr == 1 && df * df == 1) w_map[t] = 1'b1;
                     KNIGHT:       if (knight_step) w_map[t] = 1'b1;
                     KING:         if (king_step) w_map[t] = 1'b1;
                     BLACK_PAWN:   if (dr == -1 && df * df == 1) b_map[t] = 1'b1;
                     BLACK_KNIGHT: if (knight_step) b_map[t] = 1'b1;
                     BLACK_KING:   if (king_step) b_map[t] = 1'b1;
                     default: ;
                  endcase
               end
            end
         end
      end
      w_check = 1'b0;
      b_check = 1'b0;
      for (int s = 0; s < 64; s++)
      begin
         if (b[s * 4 +: 4] == KING && b_map[s])
            w_check = 1'b1;
         if (b[s * 4 +: 4] == BLACK_KING && w_map[s])
            b_check = 1'b1;
      end
   endfunction

   task automatic axi_write(input int word, input logic [31:0] data, input int stall);
      @(posedge clk);
      axi_awaddr <= ADDR_WIDTH'(word * 4);
      axi_wdata <= data;
      axi_awvalid <= 1'b1;
      axi_wvalid <= 1'b1;
      @(negedge clk);
      while (!axi_awready)
         @(negedge clk);
      check_value("wready", 64'(axi_wready), 64'h1);  // Raised together with awready
      @(posedge clk);                              // Address and data taken here
      axi_awvalid <= 1'b0;
      axi_wvalid <= 1'b0;
      repeat (stall) @(posedge clk);               // Response held off
      axi_bready <= 1'b1;
      @(negedge clk);
      while (!axi_bvalid)
         @(negedge clk);
      check_value("bresp", 64'(axi_bresp), 64'h0);
      @(posedge clk);
      axi_bready <= 1'b0;
   endtask

   task automatic axi_read(input int word, output logic [31:0] data, input int stall);
      @(posedge clk);
      axi_araddr <= ADDR_WIDTH'(word * 4);
      axi_arvalid <= 1'b1;
      @(negedge clk);
      check_value("arready", 64'(axi_arready), 64'h1);
      @(posedge clk);                              // Address taken here
      axi_arvalid <= 1'b0;
      repeat (stall) @(posedge clk);
      axi_rready <= 1'b1;
      @(negedge clk);
      while (!axi_rvalid)
         @(negedge clk);
      data = axi_rdata;
      check_value("rresp", 64'(axi_rresp), 64'h0);
      @(posedge clk);
      axi_rready <= 1'b0;
   endtask

   task automatic load_position(input logic [BOARD_WIDTH - 1:0] b, input logic [8:0] side,
                                input int stall);
      for (int r = 0; r < 8; r++)
         axi_write(REG_RANK0 + r, b[r * SIDE_WIDTH +: SIDE_WIDTH], stall);
      axi_write(REG_SIDE, 32'(side), stall);
   endtask

   task automatic start_and_wait(input int stall);
      logic [31:0] status;
      int          polls;

      axi_write(REG_STATUS, 32'h1, stall);
      polls = 0;
      status = '0;
      while (!status[0] && polls < 16)
      begin
         axi_read(REG_STATUS, status, stall);
         polls++;
      end
      if (!status[0])
      begin
         errors++;
         $display("** Error: ready did not rise after start");
      end
   endtask

   task automatic compare_results(input logic [BOARD_WIDTH - 1:0] b, input int stall);
      logic [63:0] w_map;
      logic [63:0] b_map;
      logic        w_check;
      logic        b_check;
      logic [31:0] lo;
      logic [31:0] hi;

      attack_model(b, w_map, b_map, w_check, b_check);
      axi_read(REG_WATK_LO, lo, stall);
      axi_read(REG_WATK_HI, hi, stall);
      check_value("white_attack", {hi, lo}, w_map);
      axi_read(REG_BATK_LO, lo, stall);
      axi_read(REG_BATK_HI, hi, stall);
      check_value("black_attack", {hi, lo}, b_map);
      axi_read(REG_CHECK, lo, stall);
      check_value("check", 64'(lo), {62'd0, b_check, w_check});
   endtask

   task automatic ready_and_clear();
      logic [31:0] status;

      axi_read(REG_STATUS, status, 0);
      check_value("status", 64'(status), 64'h0);  // Nothing analysed yet
      start_and_wait(0);
      axi_read(REG_STATUS, status, 0);
      check_value("status", 64'(status), 64'h1);
      axi_write(REG_STATUS, 32'h2, 0);
      axi_read(REG_STATUS, status, 0);
      check_value("status", 64'(status), 64'h0);
   endtask

   task automatic register_readback();
      logic [31:0] data;
      int          unmapped[4];

      unmapped = '{1, 3, 100, 1024};
      for (int r = 0; r < 8; r++)
         axi_write(REG_RANK0 + r, 32'hA5C3_0F96 ^ (32'(r) * 32'h1111_1111), 0);
      axi_write(REG_SIDE, 32'hFFFF_F15A, 0);
      for (int r = 0; r < 8; r++)
      begin
         axi_read(REG_RANK0 + r, data, 0);
         check_value("rank", 64'(data), 64'(32'hA5C3_0F96 ^ (32'(r) * 32'h1111_1111)));
      end
      axi_read(REG_SIDE, data, 0);
      check_value("side", 64'(data), 64'h15A);   // Only 9 bits are kept
      foreach (unmapped[i])
      begin
         axi_read(unmapped[i], data, 0);
         check_value("unmapped", 64'(data), 64'h0);
      end
   endtask

   task automatic knight_king_attacks();
      logic [BOARD_WIDTH - 1:0] b;

      b = '0;
      b[27 * 4 +: 4] = KNIGHT;                     // d4
      b[63 * 4 +: 4] = BLACK_KING;                 // h8
      load_position(b, 9'h100, 0);
      start_and_wait(0);
      compare_results(b, 0);
   endtask

   task automatic pawn_edge_attacks();
      logic [BOARD_WIDTH - 1:0] b;

      b = '0;
      b[0 * 4 +: 4] = PAWN;                        // a1
      b[15 * 4 +: 4] = PAWN;                       // h2
      b[55 * 4 +: 4] = PAWN;                       // h7
      b[63 * 4 +: 4] = PAWN;                       // h8, nowhere to go
      b[56 * 4 +: 4] = BLACK_PAWN;                 // a8
      b[7 * 4 +: 4] = BLACK_PAWN;                  // h1, nowhere to go
      b[32 * 4 +: 4] = BLACK_PAWN;                 // a5
      b[31 * 4 +: 4] = BLACK_PAWN;                 // h4
      load_position(b, 9'h0F3, 0);
      start_and_wait(0);
      compare_results(b, 0);
   endtask

   task automatic latch_and_check_flags();
      logic [BOARD_WIDTH - 1:0] b;
      logic [31:0]              data;

      b = '0;
      b[45 * 4 +: 4] = KNIGHT;                     // f6 hits e8
      b[60 * 4 +: 4] = BLACK_KING;                 // e8
      b[4 * 4 +: 4] = KING;                        // e1
      load_position(b, 9'h1F0, 0);
      start_and_wait(0);
      axi_read(REG_CHECK, data, 0);
      check_value("check", 64'(data), 64'h2);
      compare_results(b, 0);
      axi_write(REG_RANK7, 32'h0, 0);              // Edit after start
      axi_write(REG_SIDE, 32'h0, 0);
      axi_read(REG_LRANK7, data, 0);
      check_value("latched_rank7", 64'(data), 64'(b[7 * SIDE_WIDTH +: SIDE_WIDTH]));
      axi_read(REG_LSIDE, data, 0);
      check_value("latched_side", 64'(data), 64'h1F0);
      b[7 * SIDE_WIDTH +: SIDE_WIDTH] = '0;
      start_and_wait(0);
      axi_read(REG_LRANK7, data, 0);
      check_value("latched_rank7", 64'(data), 64'h0);
      compare_results(b, 0);
   endtask

   task automatic random_board_sweep();
      logic [BOARD_WIDTH - 1:0] b;
      logic [8:0]               side;

      for (int n = 0; n < RANDOM_BOARDS; n++)
      begin
         for (int s = 0; s < 64; s++)
         begin
            rand_state = lcg_next(rand_state);
            if (rand_state[31:29] < 3'd5)
               b[s * 4 +: 4] = EMPTY;              // Keep boards sparse
            else
               b[s * 4 +: 4] = {rand_state[28], 3'(rand_state[27:16] % 6 + 1)};
         end
         rand_state = lcg_next(rand_state);
         side = rand_state[8:0];
         load_position(b, side, 2);
         start_and_wait(2);
         compare_results(b, 2);
      end
   endtask

   initial
   begin
      checks = 0;
      errors = 0;
      rand_state = 32'he42d_de23;
      reset = 1'b1;
      axi_araddr = '0;
      axi_arprot = 3'b000;
      axi_arvalid = 1'b0;
      axi_awaddr = '0;
      axi_awprot = 3'b000;
      axi_awvalid = 1'b0;
      axi_bready = 1'b0;
      axi_rready = 1'b0;
      axi_wdata = '0;
      axi_wstrb = 4'hF;
      axi_wvalid = 1'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      ready_and_clear();                           // Must run straight after reset
      register_readback();
      knight_king_attacks();
      pawn_edge_attacks();
      latch_and_check_flags();
      random_board_sweep();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule
